/* hw/nco_pkg.sv */
package nco_pkg;

    // host command opcodes
    typedef enum logic [1:0] {
        OP_NOP         = 2'd0,
        OP_SET_FREQ    = 2'd1,
        OP_SET_SHAPE   = 2'd2,
        OP_CLEAR_PHASE = 2'd3
    } nco_opcode_t;

    // unity gain, the scaler shifts right by 7
    localparam logic [7:0] GAIN_UNITY = 8'd128;

    typedef struct packed {
        logic [13:0] pad;
        logic [15:0] tuning;
    } nco_freq_view_t;

    typedef struct packed {
        logic [5:0]  pad;
        logic [7:0]  gain;
        logic [15:0] offset;
    } nco_shape_view_t;

    // same payload bits, read by opcode
    typedef union packed {
        nco_freq_view_t  freq;
        nco_shape_view_t shape;
    } nco_payload_u;

    typedef struct packed {
        nco_opcode_t  opcode;
        nco_payload_u payload;
    } nco_cmd_t;

    typedef struct packed {
        logic [15:0] tuning;
        logic [15:0] offset;
        logic [7:0]  gain;
    } nco_settings_t;

endpackage

/* hw/wave_pkg.sv */
package wave_pkg;

    localparam int PHASE_BITS  = 16;
    localparam int SAMPLE_BITS = 16;

    // phase word handed from the accumulator to the table
    typedef struct packed {
        logic                  valid;
        logic [PHASE_BITS-1:0] phase;
    } phase_t;

    // signed sample between table, scaler and output
    typedef struct packed {
        logic                          valid;
        logic signed [SAMPLE_BITS-1:0] value;
    } sample_t;

endpackage

/* hw/nco_cmd_decode.sv */
`timescale 1ns/1ns

module nco_cmd_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  nco_pkg::nco_cmd_t     cmd,
    output nco_pkg::nco_settings_t settings,
    output logic                  phase_clear
);
    import nco_pkg::*;

    nco_freq_view_t  freq_view;
    nco_shape_view_t shape_view;

    // both readings of the payload, the opcode picks one
    always_comb begin
        freq_view  = cmd.payload.freq;
        shape_view = cmd.payload.shape;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            settings.tuning <= '0;
            settings.offset <= '0;
            settings.gain   <= GAIN_UNITY;
            phase_clear     <= 1'b0;
        end else begin
            // clear is a single cycle pulse
            phase_clear <= 1'b0;
            if (cmd_valid) begin
                case (cmd.opcode)
                    OP_SET_FREQ: begin
                        settings.tuning <= freq_view.tuning;
                    end
                    OP_SET_SHAPE: begin
                        settings.offset <= shape_view.offset;
                        settings.gain   <= shape_view.gain;
                    end
                    OP_CLEAR_PHASE: begin
                        phase_clear <= 1'b1;
                    end
                    default: begin
                        // nop keeps everything as it is
                    end
                endcase
            end
        end
    end

endmodule

/* hw/phase_accumulator.sv */
`timescale 1ns/1ns

module phase_accumulator #(
    parameter int PHASE_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  logic                   phase_clear,
    input  logic [PHASE_WIDTH-1:0] tuning,
    input  logic [PHASE_WIDTH-1:0] offset,
    output wave_pkg::phase_t       phase
);

    logic [PHASE_WIDTH-1:0] acc;
    logic [PHASE_WIDTH-1:0] acc_now;

    // a clear zeroes the value used in this very cycle,
    // so the next enabled cycle starts from phase 0
    assign acc_now = phase_clear ? '0 : acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (en) begin
            // wraps naturally at 2**PHASE_WIDTH
            acc <= acc_now + tuning;
        end else begin
            acc <= acc_now;
        end
    end

    // phase before the addition, shifted by the offset
    always_ff @(posedge clk) begin
        phase.phase <= acc_now + offset;
        if (rst) begin
            phase.valid <= 1'b0;
        end else begin
            phase.valid <= en;
        end
    end

endmodule

/* hw/quarter_sine_lut.sv */
`timescale 1ns/1ns

module quarter_sine_lut #(
    parameter int PHASE_WIDTH  = 16,
    parameter int SAMPLE_WIDTH = 16,
    parameter int TABLE_BITS   = 5
) (
    input  logic              clk,
    input  logic              rst,
    input  wave_pkg::phase_t  phase,
    output wave_pkg::sample_t raw
);

    localparam int STEPS = 2 ** TABLE_BITS;
    localparam int PEAK  = 2 ** (SAMPLE_WIDTH - 2) - 1;
    localparam real PI   = 3.14159265358979;

    // one extra word so the peak is reachable when mirroring
    typedef logic [SAMPLE_WIDTH-1:0] table_t [0:STEPS];

    function automatic table_t build_table();
        table_t t;
        real    angle;
        for (int k = 0; k <= STEPS; k++) begin
            angle = 2.0 * PI * k / (4.0 * STEPS);
            t[k]  = SAMPLE_WIDTH'($rtoi(PEAK * $sin(angle) + 0.5));
        end
        return t;
    endfunction

    localparam table_t SINE_TABLE = build_table();

    logic [TABLE_BITS+1:0]          index;
    logic [1:0]                     quadrant;
    logic [TABLE_BITS-1:0]          step;
    logic [TABLE_BITS:0]            addr;
    logic signed [SAMPLE_WIDTH-1:0] mag;

    assign index    = phase.phase[PHASE_WIDTH-1 -: TABLE_BITS+2];
    assign quadrant = index[TABLE_BITS+1:TABLE_BITS];
    assign step     = index[TABLE_BITS-1:0];

    // odd quadrants run the table backwards
    always_comb begin
        if (quadrant[0]) begin
            addr = (TABLE_BITS+1)'(STEPS) - {1'b0, step};
        end else begin
            addr = {1'b0, step};
        end
        mag = $signed(SINE_TABLE[addr]);
    end

    always_ff @(posedge clk) begin
        // second half of the period is negative
        raw.value <= quadrant[1] ? -mag : mag;
        if (rst) begin
            raw.valid <= 1'b0;
        end else begin
            raw.valid <= phase.valid;
        end
    end

endmodule

/* hw/amplitude_scaler.sv */
`timescale 1ns/1ns

module amplitude_scaler #(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  wave_pkg::sample_t raw,
    input  logic [7:0]        gain,
    output wave_pkg::sample_t sample
);

    localparam int PROD_WIDTH = SAMPLE_WIDTH + 9;
    localparam logic signed [SAMPLE_WIDTH-1:0] MAX_VAL = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
    localparam logic signed [SAMPLE_WIDTH-1:0] MIN_VAL = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

    logic [7:0]                     gain_q1;
    logic [7:0]                     gain_q2;
    logic signed [PROD_WIDTH-1:0]   product;
    logic signed [PROD_WIDTH-1:0]   scaled;
    logic signed [SAMPLE_WIDTH-1:0] clipped;

    // gain delayed by the accumulator and table registers
    // so each sample is scaled with the gain of its own enabled cycle
    always_ff @(posedge clk) begin
        gain_q1 <= gain;
        gain_q2 <= gain_q1;
    end

    always_comb begin
        // gain is unsigned, 128 is unity
        product = $signed(raw.value) * $signed({1'b0, gain_q2});
        scaled  = product >>> 7;
        if (scaled > MAX_VAL) begin
            clipped = MAX_VAL;
        end else if (scaled < MIN_VAL) begin
            clipped = MIN_VAL;
        end else begin
            clipped = scaled[SAMPLE_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        sample.value <= clipped;
        if (rst) begin
            sample.valid <= 1'b0;
        end else begin
            sample.valid <= raw.valid;
        end
    end

endmodule

/* hw/nco_top.sv */
`timescale 1ns/1ns

module nco_top #(
    parameter int PHASE_WIDTH  = 16,
    parameter int SAMPLE_WIDTH = 16,
    parameter int TABLE_BITS   = 5
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  logic                           cmd_valid,
    input  nco_pkg::nco_cmd_t              cmd,
    output logic signed [SAMPLE_WIDTH-1:0] sample,
    output logic                           sample_valid
);
    import nco_pkg::*;
    import wave_pkg::*;

    nco_settings_t settings;
    logic          phase_clear;
    phase_t        phase;
    sample_t       raw;
    sample_t       result;

    // decode
    nco_cmd_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .settings    (settings),
        .phase_clear (phase_clear)
    );

    // execute
    phase_accumulator #(
        .PHASE_WIDTH (PHASE_WIDTH)
    ) i_accumulator (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .phase_clear (phase_clear),
        .tuning      (settings.tuning),
        .offset      (settings.offset),
        .phase       (phase)
    );

    quarter_sine_lut #(
        .PHASE_WIDTH  (PHASE_WIDTH),
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .TABLE_BITS   (TABLE_BITS)
    ) i_lut (
        .clk   (clk),
        .rst   (rst),
        .phase (phase),
        .raw   (raw)
    );

    // result
    amplitude_scaler #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) i_scaler (
        .clk    (clk),
        .rst    (rst),
        .raw    (raw),
        .gain   (settings.gain),
        .sample (result)
    );

    assign sample       = result.value;
    assign sample_valid = result.valid;

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

/* test/nco_checker.sv */
`timescale 1ns/1ns

module nco_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic              cmd_valid,
    input  nco_pkg::nco_cmd_t cmd,
    input  logic [15:0]       final_expected,
    input  logic signed [15:0] sample,
    input  logic              sample_valid,
    output int                error_count,
    output int                sample_count,
    output int                run_count
);

    logic [31:0] word;
    logic [15:0] tuning_m;
    logic [15:0] offset_m;
    logic [7:0]  gain_m;
    logic        clear_m;
    logic [15:0] acc_m;
    logic [15:0] start;
    logic        p_valid;
    logic [15:0] p_phase;
    logic [7:0]  p_gain;
    logic        r_valid;
    int          r_value;
    logic        s_valid;
    int          s_value;
    logic        last_valid;
    logic [15:0] last_sample;
    logic [15:0] final_q[$];

    assign word  = cmd;
    assign start = clear_m ? 16'd0 : acc_m;

    // rounded 16383 * sin(2*pi*k/128)
    function automatic int table_entry(input int k);
        real angle;
        angle = 2.0 * 3.141592653589793 * k / 128.0;
        return $rtoi($floor(16383.0 * $sin(angle) + 0.5));
    endfunction

    function automatic int raw_from_phase(input logic [15:0] p);
        int idx;
        int quad;
        int i;
        idx  = int'(p) / 512;
        quad = idx / 32;
        i    = idx % 32;
        case (quad)
            0: return table_entry(i);
            1: return table_entry(32 - i);
            2: return -table_entry(i);
            default: return -table_entry(32 - i);
        endcase
    endfunction

    // multiply by gain, floor divide by 128, clip to 16 bits
    function automatic int scale(input int raw, input int g);
        int prod;
        int res;
        prod = raw * g;
        res  = (prod >= 0) ? prod / 128 : -((-prod + 127) / 128);
        if (res > 32767) res = 32767;
        if (res < -32768) res = -32768;
        return res;
    endfunction

    initial begin
        error_count  = 0;
        sample_count = 0;
        run_count    = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            tuning_m   <= '0;
            offset_m   <= '0;
            gain_m     <= 8'd128;
            clear_m    <= 1'b0;
            acc_m      <= '0;
            p_valid    <= 1'b0;
            r_valid    <= 1'b0;
            s_valid    <= 1'b0;
            last_valid <= 1'b0;
        end else begin
            // model of the decoder, opcode in the top two bits
            clear_m <= 1'b0;
            if (cmd_valid) begin
                final_q.push_back(final_expected);
                case (word[31:30])
                    2'd1: tuning_m <= word[15:0];
                    2'd2: begin
                        offset_m <= word[15:0];
                        gain_m   <= word[23:16];
                    end
                    2'd3: clear_m <= 1'b1;
                    default: ;
                endcase
            end
            acc_m   <= en ? start + tuning_m : start;
            p_valid <= en;
            p_phase <= start + offset_m;
            // gain travels with the phase of its enabled cycle
            p_gain  <= gain_m;
            r_valid <= p_valid;
            r_value <= scale(raw_from_phase(p_phase), int'(p_gain));
            s_valid <= r_valid;
            s_value <= r_value;

            if (sample_valid && !s_valid) begin
                $display("sample_valid went high when no sample was expected at %0t", $time);
                error_count <= error_count + 1;
            end else if (!sample_valid && s_valid) begin
                $display("an expected sample did not appear at %0t", $time);
                error_count <= error_count + 1;
            end else if (sample_valid) begin
                sample_count <= sample_count + 1;
                if (sample !== 16'(s_value)) begin
                    $display("Error sample expected %h got %h", 16'(s_value), sample);
                    error_count <= error_count + 1;
                end
            end

            // end of a run, compare its last sample with the vectors file
            if (last_valid && !sample_valid) begin
                run_count <= run_count + 1;
                if (final_q.size() == 0) begin
                    $display("a run ended with no expected final sample queued");
                    error_count <= error_count + 1;
                end else if (last_sample !== final_q[0]) begin
                    $display("Error final sample expected %h got %h", final_q[0], last_sample);
                    error_count <= error_count + 1;
                    final_q.pop_front();
                end else begin
                    final_q.pop_front();
                end
            end
            last_valid  <= sample_valid;
            last_sample <= sample;
        end
    end

endmodule

/* test/nco_assert.sv */
`timescale 1ns/1ns

module nco_assert (
    input logic              clk,
    input logic              rst,
    input logic              en,
    input logic              sample_valid,
    input logic signed [15:0] sample,
    input logic [7:0]        gain
);

    // largest magnitude of a table peak after scaling
    function automatic int peak_limit(input logic [7:0] g);
        return (16383 * int'(g)) / 128;
    endfunction

    valid_low_after_reset: assert property (@(posedge clk) rst |=> !sample_valid)
        else $error("sample_valid high right after reset");

    valid_follows_en: assert property (@(posedge clk) disable iff (rst)
        sample_valid == $past(en, 3))
        else $error("sample_valid is not en delayed by 3 cycles");

    // the gain of the enabled cycle three cycles back applies
    sample_in_range: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> (int'(sample) <= peak_limit($past(gain, 3))
                          && int'(sample) >= -peak_limit($past(gain, 3)) - 1))
        else $error("sample outside the range allowed by the gain");

endmodule

bind nco_top nco_assert i_assert (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .sample_valid (sample_valid),
    .sample       (sample),
    .gain         (settings.gain)
);

/* test/nco_tb.sv */
`timescale 1ns/1ns

module nco_tb;
    import nco_pkg::*;

    localparam int MAX_WORDS    = 96;
    localparam int RESET_CYCLES = 8;

    logic               clk;
    logic               rst;
    logic               en;
    logic               cmd_valid;
    nco_cmd_t           cmd;
    logic [15:0]        final_expected;
    logic signed [15:0] sample;
    logic               sample_valid;
    logic [31:0]        vec_mem [0:MAX_WORDS-1];
    int                 num_runs;
    int                 total_cycles;
    int                 cycle_count;
    int                 cycle_limit;
    int                 error_count;
    int                 sample_count;
    int                 run_count;

    tb_clock_gen #(.PERIOD(100)) i_clock (.clk(clk));

    nco_top i_nco_top (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    nco_checker i_checker (
        .clk            (clk),
        .rst            (rst),
        .en             (en),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .final_expected (final_expected),
        .sample         (sample),
        .sample_valid   (sample_valid),
        .error_count    (error_count),
        .sample_count   (sample_count),
        .run_count      (run_count)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int gap;
        rst            = 1'b1;
        en             = 1'b0;
        cmd_valid      = 1'b0;
        cmd            = '0;
        final_expected = '0;
        cycle_count    = 0;
        cycle_limit    = 0;
        num_runs       = 0;
        total_cycles   = 0;
        void'($urandom(32'h8ecf_b78a));
        for (int i = 0; i < MAX_WORDS; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("test/nco_vectors.txt", vec_mem);
        // three words per run, a zero count ends the list
        while (num_runs * 3 + 2 < MAX_WORDS && vec_mem[num_runs * 3 + 1] != 0) begin
            total_cycles = total_cycles + int'(vec_mem[num_runs * 3 + 1]);
            num_runs     = num_runs + 1;
        end
        cycle_limit = total_cycles + 4 * num_runs + RESET_CYCLES + 16;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < num_runs; r++) begin
            cmd_valid      <= 1'b1;
            cmd            <= nco_cmd_t'(vec_mem[r * 3]);
            final_expected <= vec_mem[r * 3 + 2][15:0];
            @(posedge clk);
            cmd_valid <= 1'b0;
            en        <= 1'b1;
            repeat (int'(vec_mem[r * 3 + 1])) @(posedge clk);
            en <= 1'b0;
            // random idle gap with en low
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
        end
        while (run_count < num_runs) @(posedge clk);
        @(posedge clk);
        $display("runs %0d of %0d, samples %0d, errors %0d",
                 run_count, num_runs, sample_count, error_count);
        if (error_count == 0 && run_count == num_runs) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
hw/nco_pkg.sv
hw/wave_pkg.sv
hw/nco_cmd_decode.sv
hw/phase_accumulator.sv
hw/quarter_sine_lut.sv
hw/amplitude_scaler.sv
hw/nco_top.sv
test/tb_clock_gen.sv
test/nco_checker.sv
test/nco_assert.sv
test/nco_tb.sv

/* Makefile */
# Verilator build and run for the NCO testbench

VERILATOR ?= verilator
TOP       ?= nco_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* test/nco_vectors.txt */
// columns: command word, enabled cycles, expected final sample (all hex)
// opcode in bits 31:30, tuning or offset in 15:0, gain in 23:16
// one step per cycle, full period ending back at phase 0
40000200 81 0000
// five steps per cycle, ends on the negative peak
40000A00 14 C001
// negative tuning wraps the accumulator, ends on the positive peak
4000F600 42 3FFF
// quarter offset and half gain
80404000 20 1FFF
// clear restarts at the offset
C0000000 01 1FFF
// gain 255 at the negative peak
80FF0000 20 8081
// nop with a nonzero payload
00123456 20 0000
40000200 26 8081
80800000 20 0000
// clear then one quarter period to the peak
C0000000 21 3FFF
